// File: rtl/aluPkg.sv
package aluPkg;

    typedef logic [15:0] word_t;
    typedef logic [3:0]  nibble_t;

    // [5] mode (1 = logic), [4:1] function select, [0] carry-in
    typedef logic [5:0] aluOp_t;

    typedef logic [3:0] aluSel_t;

    // [0] carry out of bit 15, [1] negative, [2] zero
    typedef logic [2:0] aluFlags_t;

    localparam int FLAG_C = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_Z = 2;

    // logic mode selects, 74181 active-high encoding
    localparam aluSel_t SEL_NOT = 4'b0000;
    localparam aluSel_t SEL_AND = 4'b1011;
    localparam aluSel_t SEL_OR  = 4'b1110;
    localparam aluSel_t SEL_XOR = 4'b0110;

    // arithmetic mode selects
    localparam aluSel_t SEL_ADD = 4'b1001;
    localparam aluSel_t SEL_SUB = 4'b0110;
    localparam aluSel_t SEL_INC = 4'b0000;

endpackage

// File: rtl/clusterPkg.sv
package clusterPkg;

    // size of the shared register file
    localparam int REG_COUNT = 16;
    localparam int ADDR_W = (REG_COUNT > 1) ? $clog2(REG_COUNT) : 1;

    typedef logic [ADDR_W-1:0] regAddr_t;

    // requesters behind the host port
    localparam int ENG_COUNT = 2;

    typedef logic [$clog2(ENG_COUNT)-1:0] reqIdx_t;

    // one read per operand, then compute, then write back
    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_READA,
        ENG_READB,
        ENG_EXEC,
        ENG_WRITE
    } engState_t;

endpackage

// File: rtl/regBusIf.sv
`timescale 1ns/1ps

interface regBusIf;

    logic                 req;
    logic                 we;
    clusterPkg::regAddr_t addr;
    aluPkg::word_t        wdata;
    logic                 gnt;
    // valid the cycle after a read grant
    aluPkg::word_t        rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

// File: rtl/bitsliceAlu.sv
`timescale 1ns/1ps

module aluSlice4 (
    input  aluPkg::nibble_t a,
    input  aluPkg::nibble_t b,
    input  aluPkg::aluSel_t sel,
    input  logic            logicMode,
    input  logic            cin,
    output aluPkg::nibble_t f,
    output logic            p,
    output logic            g
);

    aluPkg::nibble_t y;
    aluPkg::nibble_t bitP;
    aluPkg::nibble_t bitG;
    aluPkg::nibble_t sum;
    aluPkg::nibble_t logicF;
    logic [3:0]      c;
    logic            arith;

    // second adder operand
    always_comb begin
        arith = 1'b1;
        y = '0;
        case (sel)
            aluPkg::SEL_ADD: y = b;
            aluPkg::SEL_SUB: y = ~b;
            aluPkg::SEL_INC: y = '0;
            default:         arith = 1'b0;
        endcase
    end

    always_comb begin
        case (sel)
            aluPkg::SEL_NOT: logicF = ~a;
            aluPkg::SEL_AND: logicF = a & b;
            aluPkg::SEL_OR:  logicF = a | b;
            aluPkg::SEL_XOR: logicF = a ^ b;
            default:         logicF = a;
        endcase
    end

    assign bitP = a ^ y;
    assign bitG = a & y;

    // ripple inside the nibble
    assign c[0] = cin;
    assign c[1] = bitG[0] | (bitP[0] & c[0]);
    assign c[2] = bitG[1] | (bitP[1] & c[1]);
    assign c[3] = bitG[2] | (bitP[2] & c[2]);
    assign sum  = bitP ^ c;

    assign f = logicMode ? logicF : (arith ? sum : a);

    // group terms, zero outside arithmetic so no carry leaves the slice
    assign p = ~logicMode & arith & (&bitP);
    assign g = ~logicMode & arith & (bitG[3]
             | (bitP[3] & bitG[2])
             | (bitP[3] & bitP[2] & bitG[1])
             | (bitP[3] & bitP[2] & bitP[1] & bitG[0]));

endmodule

module bitsliceAlu (
    input  aluPkg::word_t     a,
    input  aluPkg::word_t     b,
    input  aluPkg::aluOp_t    op,
    output aluPkg::word_t     q,
    output aluPkg::aluFlags_t flags
);

    logic [3:0] grpP;
    logic [3:0] grpG;
    logic [4:0] carry;

    genvar i;
    generate
        for (i = 0; i < 4; i++) begin : gSlice
            aluSlice4 slice (
                .a        (a[i*4 +: 4]),
                .b        (b[i*4 +: 4]),
                .sel      (op[4:1]),
                .logicMode(op[5]),
                .cin      (carry[i]),
                .f        (q[i*4 +: 4]),
                .p        (grpP[i]),
                .g        (grpG[i])
            );
        end
    endgenerate

    // lookahead across the four slices
    assign carry[0] = op[0];
    assign carry[1] = grpG[0] | (grpP[0] & carry[0]);
    assign carry[2] = grpG[1] | (grpP[1] & grpG[0]) | (grpP[1] & grpP[0] & carry[0]);
    assign carry[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
                    | (grpP[2] & grpP[1] & grpP[0] & carry[0]);
    assign carry[4] = grpG[3] | (grpP[3] & grpG[2]) | (grpP[3] & grpP[2] & grpG[1])
                    | (grpP[3] & grpP[2] & grpP[1] & grpG[0])
                    | (grpP[3] & grpP[2] & grpP[1] & grpP[0] & carry[0]);

    assign flags[aluPkg::FLAG_C] = carry[4];
    assign flags[aluPkg::FLAG_N] = q[15];
    assign flags[aluPkg::FLAG_Z] = (q == '0);

endmodule

// File: rtl/regArbiter.sv
`timescale 1ns/1ps

module regArbiter #(
    parameter int REG_COUNT = clusterPkg::REG_COUNT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hostWe,
    input  logic                 hostRe,
    input  clusterPkg::regAddr_t hostAddr,
    input  aluPkg::word_t        hostWdata,
    output aluPkg::word_t        hostRdata,
    regBusIf.arbiter             eng0,
    regBusIf.arbiter             eng1
);

    aluPkg::word_t regs [REG_COUNT];

    logic [clusterPkg::ENG_COUNT-1:0] req;
    logic [clusterPkg::ENG_COUNT-1:0] wr;
    logic [clusterPkg::ENG_COUNT-1:0] gnt;
    clusterPkg::regAddr_t             addr [clusterPkg::ENG_COUNT];
    aluPkg::word_t                    wdata [clusterPkg::ENG_COUNT];
    aluPkg::word_t                    rdataQ [clusterPkg::ENG_COUNT];
    clusterPkg::reqIdx_t              rrPtr;
    logic                             hostCycle;

    assign req      = {eng1.req, eng0.req};
    assign wr       = {eng1.we, eng0.we};
    assign addr[0]  = eng0.addr;
    assign addr[1]  = eng1.addr;
    assign wdata[0] = eng0.wdata;
    assign wdata[1] = eng1.wdata;

    assign hostCycle = hostWe | hostRe;

    // host first, then whichever engine the pointer favours
    always_comb begin
        gnt = '0;
        if (!hostCycle) begin
            if (req[0] && (!req[1] || rrPtr == clusterPkg::reqIdx_t'(0))) begin
                gnt[0] = 1'b1;
            end else if (req[1]) begin
                gnt[1] = 1'b1;
            end
        end
    end

    assign eng0.gnt   = gnt[0];
    assign eng1.gnt   = gnt[1];
    assign eng0.rdata = rdataQ[0];
    assign eng1.rdata = rdataQ[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < REG_COUNT; r++) begin
                regs[r] <= '0;
            end
            rrPtr <= '0;
            hostRdata <= '0;
        end else begin
            if (hostWe) begin
                regs[hostAddr] <= hostWdata;
            end
            if (hostRe) begin
                hostRdata <= regs[hostAddr];
            end
            for (int e = 0; e < clusterPkg::ENG_COUNT; e++) begin
                if (gnt[e] && wr[e]) begin
                    regs[addr[e]] <= wdata[e];
                end
            end
            // the engine just served drops to the back
            if (gnt[0]) begin
                rrPtr <= clusterPkg::reqIdx_t'(1);
            end else if (gnt[1]) begin
                rrPtr <= clusterPkg::reqIdx_t'(0);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < clusterPkg::ENG_COUNT; e++) begin
            if (gnt[e] && !wr[e]) begin
                rdataQ[e] <= regs[addr[e]];
            end
        end
    end

endmodule

// File: rtl/opEngine.sv
`timescale 1ns/1ps

module opEngine #(
    parameter int REG_COUNT = clusterPkg::REG_COUNT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  aluPkg::aluOp_t       op,
    input  clusterPkg::regAddr_t srcA,
    input  clusterPkg::regAddr_t srcB,
    input  clusterPkg::regAddr_t dst,
    output logic                 busy,
    output logic                 done,
    output aluPkg::aluFlags_t    flags,
    regBusIf.requester           bus
);

    clusterPkg::engState_t state;
    aluPkg::aluOp_t        opQ;
    clusterPkg::regAddr_t  srcAQ;
    clusterPkg::regAddr_t  srcBQ;
    clusterPkg::regAddr_t  dstQ;
    aluPkg::word_t         opA;
    aluPkg::word_t         opB;
    aluPkg::word_t         aluQ;
    aluPkg::word_t         resultQ;
    aluPkg::aluFlags_t     aluFlags;
    // high in the cycle after a read grant
    logic                  dataCycle;

    // keep indices inside the register file
    function automatic clusterPkg::regAddr_t wrapAddr(clusterPkg::regAddr_t a);
        return clusterPkg::regAddr_t'(a % REG_COUNT);
    endfunction

    bitsliceAlu alu (
        .a    (opA),
        .b    (opB),
        .op   (opQ),
        .q    (aluQ),
        .flags(aluFlags)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= clusterPkg::ENG_IDLE;
            dataCycle <= 1'b0;
            flags <= '0;
        end else begin
            case (state)
                clusterPkg::ENG_IDLE: begin
                    if (start) begin
                        state <= clusterPkg::ENG_READA;
                    end
                end
                clusterPkg::ENG_READA: begin
                    if (dataCycle) begin
                        dataCycle <= 1'b0;
                        state <= clusterPkg::ENG_READB;
                    end else if (bus.gnt) begin
                        dataCycle <= 1'b1;
                    end
                end
                clusterPkg::ENG_READB: begin
                    if (dataCycle) begin
                        dataCycle <= 1'b0;
                        state <= clusterPkg::ENG_EXEC;
                    end else if (bus.gnt) begin
                        dataCycle <= 1'b1;
                    end
                end
                clusterPkg::ENG_EXEC: begin
                    flags <= aluFlags;
                    state <= clusterPkg::ENG_WRITE;
                end
                clusterPkg::ENG_WRITE: begin
                    if (bus.gnt) begin
                        state <= clusterPkg::ENG_IDLE;
                    end
                end
                default: state <= clusterPkg::ENG_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == clusterPkg::ENG_IDLE && start) begin
            opQ <= op;
            srcAQ <= wrapAddr(srcA);
            srcBQ <= wrapAddr(srcB);
            dstQ <= wrapAddr(dst);
        end
        if (dataCycle && state == clusterPkg::ENG_READA) begin
            opA <= bus.rdata;
        end
        if (dataCycle && state == clusterPkg::ENG_READB) begin
            opB <= bus.rdata;
        end
        if (state == clusterPkg::ENG_EXEC) begin
            resultQ <= aluQ;
        end
    end

    // no request during the data cycle of a read
    assign bus.req = ((state == clusterPkg::ENG_READA || state == clusterPkg::ENG_READB)
                     && !dataCycle) || state == clusterPkg::ENG_WRITE;
    assign bus.we = (state == clusterPkg::ENG_WRITE);
    assign bus.addr = (state == clusterPkg::ENG_READA) ? srcAQ :
                      (state == clusterPkg::ENG_READB) ? srcBQ : dstQ;
    assign bus.wdata = resultQ;

    assign busy = (state != clusterPkg::ENG_IDLE);
    assign done = (state == clusterPkg::ENG_WRITE) && bus.gnt;

endmodule

// File: rtl/aluCluster.sv
`timescale 1ns/1ps

module aluCluster #(
    parameter int REG_COUNT = clusterPkg::REG_COUNT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 hostWe,
    input  logic                 hostRe,
    input  clusterPkg::regAddr_t hostAddr,
    input  aluPkg::word_t        hostWdata,
    output aluPkg::word_t        hostRdata,
    input  logic                 start0,
    input  aluPkg::aluOp_t       op0,
    input  clusterPkg::regAddr_t srcA0,
    input  clusterPkg::regAddr_t srcB0,
    input  clusterPkg::regAddr_t dst0,
    output logic                 busy0,
    output logic                 done0,
    output aluPkg::aluFlags_t    flags0,
    input  logic                 start1,
    input  aluPkg::aluOp_t       op1,
    input  clusterPkg::regAddr_t srcA1,
    input  clusterPkg::regAddr_t srcB1,
    input  clusterPkg::regAddr_t dst1,
    output logic                 busy1,
    output logic                 done1,
    output aluPkg::aluFlags_t    flags1
);

    regBusIf bus0 ();
    regBusIf bus1 ();

    regArbiter #(.REG_COUNT(REG_COUNT)) arb (
        .clk      (clk),
        .rst      (rst),
        .hostWe   (hostWe),
        .hostRe   (hostRe),
        .hostAddr (hostAddr),
        .hostWdata(hostWdata),
        .hostRdata(hostRdata),
        .eng0     (bus0.arbiter),
        .eng1     (bus1.arbiter)
    );

    opEngine #(.REG_COUNT(REG_COUNT)) eng0 (
        .clk  (clk),
        .rst  (rst),
        .start(start0),
        .op   (op0),
        .srcA (srcA0),
        .srcB (srcB0),
        .dst  (dst0),
        .busy (busy0),
        .done (done0),
        .flags(flags0),
        .bus  (bus0.requester)
    );

    opEngine #(.REG_COUNT(REG_COUNT)) eng1 (
        .clk  (clk),
        .rst  (rst),
        .start(start1),
        .op   (op1),
        .srcA (srcA1),
        .srcB (srcB1),
        .dst  (dst1),
        .busy (busy1),
        .done (done1),
        .flags(flags1),
        .bus  (bus1.requester)
    );

endmodule

// File: sim/aluCluster_chk.sv
`timescale 1ns/1ps

module aluCluster_chk (
    input logic       clk,
    input logic       rst,
    input logic [1:0] gnt,
    input logic       hostCycle,
    input logic       busy,
    input logic       done
);

    // one register-file access per cycle
    property singleGrant;
        @(posedge clk) disable iff (rst) !(gnt[0] && gnt[1]);
    endproperty

    property hostOwnsCycle;
        @(posedge clk) disable iff (rst) hostCycle |-> (gnt == 2'b00);
    endproperty

    property donePulse;
        @(posedge clk) disable iff (rst) done |=> !done;
    endproperty

    property idleAfterReset;
        @(posedge clk) rst |=> !busy;
    endproperty

    assert property (singleGrant) else $error("both engines granted in one cycle");
    assert property (hostOwnsCycle) else $error("engine granted during a host access");
    assert property (donePulse) else $error("done held high for more than one cycle");
    assert property (idleAfterReset) else $error("engine busy right after reset");

endmodule

// arbiter side has no busy or done
bind regArbiter aluCluster_chk arbChk (
    .clk      (clk),
    .rst      (rst),
    .gnt      (gnt),
    .hostCycle(hostCycle),
    .busy     (1'b0),
    .done     (1'b0)
);

bind opEngine aluCluster_chk engChk (
    .clk      (clk),
    .rst      (rst),
    .gnt      (2'b00),
    .hostCycle(1'b0),
    .busy     (busy),
    .done     (done)
);

// File: sim/aluCluster_tb.sv
`timescale 1ns/1ps

module aluCluster_tb;

    localparam int MAX_CYCLES = 4000;

    logic                 clk;
    logic                 rst;
    logic                 hostWe;
    logic                 hostRe;
    clusterPkg::regAddr_t hostAddr;
    aluPkg::word_t        hostWdata;
    aluPkg::word_t        hostRdata;
    logic                 start0;
    aluPkg::aluOp_t       op0;
    clusterPkg::regAddr_t srcA0;
    clusterPkg::regAddr_t srcB0;
    clusterPkg::regAddr_t dst0;
    logic                 busy0;
    logic                 done0;
    aluPkg::aluFlags_t    flags0;
    logic                 start1;
    aluPkg::aluOp_t       op1;
    clusterPkg::regAddr_t srcA1;
    clusterPkg::regAddr_t srcB1;
    clusterPkg::regAddr_t dst1;
    logic                 busy1;
    logic                 done1;
    aluPkg::aluFlags_t    flags1;
    // expected register file contents
    aluPkg::word_t        regModel [16];
    int                   errors;
    int                   checks;
    int                   cycles;
    integer               seed;

    aluCluster uut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // result in [15:0], flags in [18:16]
    function automatic logic [18:0] aluModel(aluPkg::aluOp_t op, aluPkg::word_t a,
                                             aluPkg::word_t b);
        logic [16:0]   sum;
        aluPkg::word_t q;
        sum = {1'b0, a};
        if (op[5]) begin
            case (op[4:1])
                aluPkg::SEL_NOT: sum = {1'b0, ~a};
                aluPkg::SEL_AND: sum = {1'b0, a & b};
                aluPkg::SEL_OR:  sum = {1'b0, a | b};
                aluPkg::SEL_XOR: sum = {1'b0, a ^ b};
                default: ;
            endcase
        end else begin
            case (op[4:1])
                aluPkg::SEL_ADD: sum = {1'b0, a} + {1'b0, b} + 17'(op[0]);
                aluPkg::SEL_SUB: sum = {1'b0, a} + {1'b0, ~b} + 17'(op[0]);
                aluPkg::SEL_INC: sum = {1'b0, a} + 17'(op[0]);
                default: ;
            endcase
        end
        q = sum[15:0];
        return {(q == 16'h0000), q[15], sum[16], q};
    endfunction

    task automatic checkWord(string name, logic [15:0] got, logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic hostWrite(int addr, aluPkg::word_t data);
        @(negedge clk);
        hostWe = 1'b1;
        hostAddr = clusterPkg::regAddr_t'(addr);
        hostWdata = data;
        @(negedge clk);
        hostWe = 1'b0;
        regModel[addr] = data;
    endtask

    task automatic hostRead(int addr, output aluPkg::word_t data);
        @(negedge clk);
        hostRe = 1'b1;
        hostAddr = clusterPkg::regAddr_t'(addr);
        @(negedge clk);
        hostRe = 1'b0;
        data = hostRdata;
    endtask

    task automatic checkReg(int addr);
        aluPkg::word_t data;
        hostRead(addr, data);
        checkWord($sformatf("r%0d", addr), data, regModel[addr]);
    endtask

    task automatic setCmd(int eng, aluPkg::aluOp_t op, int a, int b, int d);
        if (eng == 0) begin
            op0 = op;
            srcA0 = clusterPkg::regAddr_t'(a);
            srcB0 = clusterPkg::regAddr_t'(b);
            dst0 = clusterPkg::regAddr_t'(d);
        end else begin
            op1 = op;
            srcA1 = clusterPkg::regAddr_t'(a);
            srcB1 = clusterPkg::regAddr_t'(b);
            dst1 = clusterPkg::regAddr_t'(d);
        end
    endtask

    task automatic pulseStart(logic s0, logic s1);
        @(negedge clk);
        start0 = s0;
        start1 = s1;
        @(negedge clk);
        start0 = 1'b0;
        start1 = 1'b0;
    endtask

    // cycles counted from the edge that samples start
    task automatic waitDone(int eng, output int lat);
        lat = 1;
        while (eng == 0 ? !done0 : !done1) begin
            @(negedge clk);
            lat++;
        end
    endtask

    task automatic runOne(int eng, aluPkg::aluOp_t op, int a, int b, int d);
        logic [18:0] exp;
        int          lat;
        exp = aluModel(op, regModel[a], regModel[b]);
        setCmd(eng, op, a, b, d);
        pulseStart(eng == 0, eng == 1);
        waitDone(eng, lat);
        checkWord($sformatf("latency%0d", eng), 16'(lat), 16'd6);
        regModel[d] = exp[15:0];
        checkReg(d);
        checkWord($sformatf("flags%0d", eng), 16'(eng == 0 ? flags0 : flags1), 16'(exp[18:16]));
    endtask

    task automatic resetTest();
        checkWord("busy0", 16'(busy0), 16'h0);
        checkWord("busy1", 16'(busy1), 16'h0);
        checkWord("done0", 16'(done0), 16'h0);
        checkWord("done1", 16'(done1), 16'h0);
        for (int r = 0; r < 16; r++) begin
            checkReg(r);
        end
    endtask

    task automatic hostTest();
        for (int r = 0; r < 16; r++) begin
            hostWrite(r, aluPkg::word_t'($random(seed)));
        end
        for (int r = 0; r < 16; r++) begin
            checkReg(r);
        end
    endtask

    task automatic logicTest();
        aluPkg::aluSel_t sels [4] = '{aluPkg::SEL_NOT, aluPkg::SEL_AND,
                                      aluPkg::SEL_OR, aluPkg::SEL_XOR};
        for (int i = 0; i < 4; i++) begin
            hostWrite(1, aluPkg::word_t'($random(seed)));
            hostWrite(2, aluPkg::word_t'($random(seed)));
            runOne(0, {1'b1, sels[i], 1'b0}, 1, 2, 3 + i);
        end
    endtask

    // pairs picked to hit carry, negative and zero
    task automatic arithTest();
        aluPkg::word_t   aVals [4] = '{16'h1234, 16'hffff, 16'h7fff, 16'h8000};
        aluPkg::word_t   bVals [4] = '{16'h1111, 16'h0001, 16'h7fff, 16'h8000};
        aluPkg::aluSel_t sels [3] = '{aluPkg::SEL_ADD, aluPkg::SEL_SUB, aluPkg::SEL_INC};
        for (int p = 0; p < 4; p++) begin
            hostWrite(4, aVals[p]);
            hostWrite(5, bVals[p]);
            for (int s = 0; s < 3; s++) begin
                for (int c = 0; c < 2; c++) begin
                    runOne(1, {1'b0, sels[s], c[0]}, 4, 5, 6);
                end
            end
        end
    endtask

    task automatic parallelTest();
        logic [18:0] exp0;
        logic [18:0] exp1;
        logic        seen0;
        logic        seen1;
        hostWrite(1, aluPkg::word_t'($random(seed)));
        hostWrite(2, aluPkg::word_t'($random(seed)));
        hostWrite(3, aluPkg::word_t'($random(seed)));
        exp0 = aluModel({1'b1, aluPkg::SEL_AND, 1'b0}, regModel[1], regModel[2]);
        exp1 = aluModel({1'b0, aluPkg::SEL_ADD, 1'b1}, regModel[2], regModel[3]);
        setCmd(0, {1'b1, aluPkg::SEL_AND, 1'b0}, 1, 2, 8);
        setCmd(1, {1'b0, aluPkg::SEL_ADD, 1'b1}, 2, 3, 9);
        pulseStart(1'b1, 1'b1);
        // engine 0 still busy so this start is dropped
        setCmd(0, {1'b1, aluPkg::SEL_OR, 1'b0}, 3, 3, 8);
        pulseStart(1'b1, 1'b0);
        // host read lands while engine 1 waits for its second grant
        checkReg(1);
        seen0 = 1'b0;
        seen1 = 1'b0;
        while (!(seen0 && seen1)) begin
            @(negedge clk);
            seen0 |= done0;
            seen1 |= done1;
        end
        regModel[8] = exp0[15:0];
        regModel[9] = exp1[15:0];
        checkReg(8);
        checkReg(9);
        checkWord("busy0", 16'(busy0), 16'h0);
        checkWord("busy1", 16'(busy1), 16'h0);
    endtask

    task automatic chainTest();
        logic [18:0]   first;
        logic [18:0]   exp;
        aluPkg::word_t data;
        first = aluModel({1'b1, aluPkg::SEL_XOR, 1'b0}, regModel[1], regModel[2]);
        exp = aluModel({1'b0, aluPkg::SEL_SUB, 1'b1}, first[15:0], regModel[3]);
        runOne(0, {1'b1, aluPkg::SEL_XOR, 1'b0}, 1, 2, 11);
        runOne(1, {1'b0, aluPkg::SEL_SUB, 1'b1}, 11, 3, 12);
        hostRead(12, data);
        checkWord("r12 chained", data, exp[15:0]);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        hostWe = 1'b0;
        hostRe = 1'b0;
        hostAddr = '0;
        hostWdata = '0;
        start0 = 1'b0;
        op0 = '0;
        srcA0 = '0;
        srcB0 = '0;
        dst0 = '0;
        start1 = 1'b0;
        op1 = '0;
        srcA1 = '0;
        srcB1 = '0;
        dst1 = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        seed = 32'h030a_652d;
        for (int r = 0; r < 16; r++) begin
            regModel[r] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        resetTest();
        hostTest();
        logicTest();
        arithTest();
        parallelTest();
        chainTest();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
rtl/aluPkg.sv
rtl/clusterPkg.sv
rtl/regBusIf.sv
rtl/bitsliceAlu.sv
rtl/regArbiter.sv
rtl/opEngine.sv
rtl/aluCluster.sv
sim/aluCluster_chk.sv
sim/aluCluster_tb.sv

// File: run.sh
#!/bin/sh
# build and run the aluCluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module aluCluster_tb -f sources.f \
    -Mdir obj_dir -o aluCluster_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/aluCluster_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
